/* parking_lot_ctrl.f */
design/parking_pkg.sv
design/sensor_filter.sv
design/passage_fsm.sv
design/occupancy_counter.sv
design/parking_lot_ctrl.sv
dv/tb_clkgen.sv
dv/parking_lot_ctrl_chk.sv
dv/tb_parking_lot_ctrl.sv

/* Bender.yml */
package:
  name: parking_lot_ctrl

sources:
  - files:
      - design/parking_pkg.sv
      - design/sensor_filter.sv
      - design/passage_fsm.sv
      - design/occupancy_counter.sv
      - design/parking_lot_ctrl.sv
  - target: simulation
    files:
      - dv/tb_clkgen.sv
      - dv/parking_lot_ctrl_chk.sv
      - dv/tb_parking_lot_ctrl.sv

/* dv/tb_parking_lot_ctrl.sv */
`timescale 1ns/1ps

module tb_parking_lot_ctrl import parking_pkg::*; ();

  typedef enum {EV_NONE, EV_ENTRY, EV_EXIT, EV_FAULT} event_t;

  // pats holds up to five {a, b} patterns, first one in the top bits
  typedef struct {
    string      name;
    bit         start;
    int         npat;
    logic [9:0] pats;
    bit         glitch;
    event_t     ev;
    int         delta;
    bit         err;
  } row_t;

  localparam int HOLD_BASE     = 3 * DEBOUNCE_CYCLES + 4;
  localparam int GLITCH_AT     = 2 * DEBOUNCE_CYCLES + 2;
  localparam int EVENT_TIMEOUT = 40;
  localparam int SETTLE_CYCLES = 4;

  logic               clk;
  logic               rst;
  logic               start;
  logic               a_raw;
  logic               b_raw;
  logic               entered;
  logic               exited;
  logic               fault;
  logic [COUNT_W-1:0] count;
  logic               full;
  logic               count_error;

  row_t        rows[$];
  logic [31:0] lfsr;
  int          n_entered;
  int          n_exited;
  int          n_fault;
  int          n_error;
  int          ref_count;
  int          rows_passed;
  int          rows_failed;
  bit          row_fail;

  tb_clkgen u_clkgen (
    .clk (clk),
    .rst (rst)
  );

  parking_lot_ctrl UUT (
    .clk         (clk),
    .rst         (rst),
    .start       (start),
    .a_raw       (a_raw),
    .b_raw       (b_raw),
    .entered     (entered),
    .exited      (exited),
    .fault       (fault),
    .count       (count),
    .full        (full),
    .count_error (count_error)
  );

  // pulse counters, sampled mid-cycle where the registered outputs are stable
  always @(negedge clk) begin
    if (!rst) begin
      if (entered) n_entered = n_entered + 1;
      if (exited) n_exited = n_exited + 1;
      if (fault) n_fault = n_fault + 1;
      if (count_error) n_error = n_error + 1;
    end
  end

  // x^32 + x^22 + x^2 + x + 1, one step per bit taken
  function automatic int unsigned rand_bits(input int n);
    int unsigned v;
    logic        fb;
    int          k;
    v = 0;
    for (k = 0; k < n; k++) begin
      fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      v    = (v << 1) | fb;
    end
    return v;
  endfunction

  function automatic void add_row(input string name, input bit start_lvl, input int npat,
                                  input logic [9:0] pats, input bit glitch,
                                  input event_t ev, input int delta, input bit err);
    row_t r;
    r.name   = name;
    r.start  = start_lvl;
    r.npat   = npat;
    r.pats   = pats;
    r.glitch = glitch;
    r.ev     = ev;
    r.delta  = delta;
    r.err    = err;
    rows.push_back(r);
  endfunction

  // every row ends with the lines back at 00, which is not listed
  function automatic void load_table();
    int k;
    add_row("entry", 1, 3, {2'b10, 2'b11, 2'b01, 4'b0}, 0, EV_ENTRY, 1, 0);
    add_row("entry_back_to_a", 1, 5, {2'b10, 2'b11, 2'b10, 2'b11, 2'b01}, 0, EV_ENTRY, 1, 0);
    add_row("entry_back_to_ab", 1, 5, {2'b10, 2'b11, 2'b01, 2'b11, 2'b01}, 0, EV_ENTRY, 1, 0);
    add_row("exit", 1, 3, {2'b01, 2'b11, 2'b10, 4'b0}, 0, EV_EXIT, -1, 0);
    add_row("exit_back_to_b", 1, 5, {2'b01, 2'b11, 2'b01, 2'b11, 2'b10}, 0, EV_EXIT, -1, 0);
    add_row("fault_idle_11", 1, 1, {2'b11, 8'b0}, 0, EV_FAULT, 0, 0);
    add_row("entry_after_fault", 1, 3, {2'b10, 2'b11, 2'b01, 4'b0}, 0, EV_ENTRY, 1, 0);
    add_row("fault_10_to_01", 1, 2, {2'b10, 2'b01, 6'b0}, 0, EV_FAULT, 0, 0);
    add_row("exit_after_fault", 1, 3, {2'b01, 2'b11, 2'b10, 4'b0}, 0, EV_EXIT, -1, 0);
    add_row("glitch_idle", 1, 1, {2'b00, 8'b0}, 1, EV_NONE, 0, 0);
    add_row("glitch_entry", 1, 3, {2'b10, 2'b11, 2'b01, 4'b0}, 1, EV_ENTRY, 1, 0);
    add_row("glitch_exit", 1, 3, {2'b01, 2'b11, 2'b10, 4'b0}, 1, EV_EXIT, -1, 0);
    add_row("entry_start_low", 0, 3, {2'b10, 2'b11, 2'b01, 4'b0}, 0, EV_NONE, 0, 0);
    add_row("exit_to_empty", 1, 3, {2'b01, 2'b11, 2'b10, 4'b0}, 0, EV_EXIT, -1, 0);
    add_row("exit_when_empty", 1, 3, {2'b01, 2'b11, 2'b10, 4'b0}, 0, EV_EXIT, 0, 1);
    for (k = 0; k < CAPACITY; k++) begin
      add_row($sformatf("fill_%0d", k + 1), 1, 3, {2'b10, 2'b11, 2'b01, 4'b0}, 0,
              EV_ENTRY, 1, 0);
    end
    add_row("entry_when_full", 1, 3, {2'b10, 2'b11, 2'b01, 4'b0}, 0, EV_ENTRY, 0, 1);
    add_row("exit_from_full", 1, 3, {2'b01, 2'b11, 2'b10, 4'b0}, 0, EV_EXIT, -1, 0);
  endfunction

  task automatic verify(input bit ok, input string msg);
    assert (ok) else begin
      $display("ERR %0t: %s", $time, msg);
      row_fail = 1'b1;
    end
  endtask

  // hold one pattern, optionally with a short opposite pulse on one line
  task automatic apply_pattern(input logic [1:0] pat, input bit glitch);
    int         hold;
    int         glen;
    logic [1:0] mask;
    hold  = HOLD_BASE + int'(rand_bits(3));
    a_raw = pat[1];
    b_raw = pat[0];
    if (glitch) begin
      glen = 1 + int'(rand_bits(2) % (DEBOUNCE_CYCLES - 2));
      mask = rand_bits(1) ? 2'b10 : 2'b01;
      repeat (GLITCH_AT) @(negedge clk);
      a_raw = pat[1] ^ mask[1];
      b_raw = pat[0] ^ mask[0];
      repeat (glen) @(negedge clk);
      a_raw = pat[1];
      b_raw = pat[0];
      repeat (hold - GLITCH_AT - glen) @(negedge clk);
    end else begin
      repeat (hold) @(negedge clk);
    end
  endtask

  task automatic wait_event(input event_t ev, output bit seen);
    int i;
    seen = 1'b0;
    for (i = 0; i < EVENT_TIMEOUT && !seen; i++) begin
      case (ev)
        EV_ENTRY: seen = (n_entered != 0);
        EV_EXIT:  seen = (n_exited != 0);
        EV_FAULT: seen = (n_fault != 0);
        default:  seen = 1'b1;
      endcase
      if (!seen) @(negedge clk);
    end
  endtask

  task automatic run_row(input int idx);
    row_t row;
    int   i;
    int   prev;
    bit   seen;
    bit   exp_err;
    row       = rows[idx];
    row_fail  = 1'b0;
    prev      = ref_count;
    exp_err   = 1'b0;
    n_entered = 0;
    n_exited  = 0;
    n_fault   = 0;
    n_error   = 0;
    start     = row.start;
    for (i = 0; i < row.npat; i++) begin
      apply_pattern(row.pats[9 - 2 * i -: 2], row.glitch);
    end
    apply_pattern(2'b00, 1'b0);
    if (row.ev != EV_NONE) begin
      wait_event(row.ev, seen);
      if (!seen) begin
        $display("timeout: expected %s pulse never arrived in row %s", row.ev.name(), row.name);
        row_fail = 1'b1;
      end
    end
    repeat (SETTLE_CYCLES) @(negedge clk);

    // reference occupancy model
    if (row.ev == EV_ENTRY) begin
      if (ref_count == CAPACITY) exp_err = 1'b1;
      else ref_count++;
    end else if (row.ev == EV_EXIT) begin
      if (ref_count == 0) exp_err = 1'b1;
      else ref_count--;
    end

    verify(n_entered == ((row.ev == EV_ENTRY) ? 1 : 0),
           $sformatf("%s: %0d entered pulses", row.name, n_entered));
    verify(n_exited == ((row.ev == EV_EXIT) ? 1 : 0),
           $sformatf("%s: %0d exited pulses", row.name, n_exited));
    verify((row.ev == EV_FAULT) ? (n_fault >= 1) : (n_fault == 0),
           $sformatf("%s: %0d fault pulses", row.name, n_fault));
    verify(int'(count) == ref_count,
           $sformatf("%s: count %0d, expected %0d", row.name, count, ref_count));
    verify(int'(count) - prev == row.delta,
           $sformatf("%s: count moved by %0d, expected %0d", row.name, int'(count) - prev,
                     row.delta));
    verify(n_error == (exp_err ? 1 : 0),
           $sformatf("%s: %0d count_error pulses, model expects %0d", row.name, n_error,
                     exp_err ? 1 : 0));
    verify(n_error == (row.err ? 1 : 0),
           $sformatf("%s: %0d count_error pulses", row.name, n_error));
    verify(full == (ref_count == CAPACITY),
           $sformatf("%s: full is %0b with count %0d", row.name, full, ref_count));

    if (row_fail) rows_failed++;
    else rows_passed++;
    $display("row %0d %s: %s", idx, row.name, row_fail ? "FAIL" : "ok");
  endtask

  initial begin
    int i;
    start       = 1'b0;
    a_raw       = 1'b0;
    b_raw       = 1'b0;
    lfsr        = 32'hbbbf72ea;
    n_entered   = 0;
    n_exited    = 0;
    n_fault     = 0;
    n_error     = 0;
    ref_count   = 0;
    rows_passed = 0;
    rows_failed = 0;
    load_table();
    @(negedge clk);
    for (i = 0; i < 50 && rst; i++) begin
      @(negedge clk);
    end
    if (rst) begin
      $display("reset was never released");
      $display("Test failed");
      $finish;
    end else begin
      foreach (rows[r]) begin
        run_row(r);
      end
      $display("rows passed %0d, rows failed %0d", rows_passed, rows_failed);
      if (rows_failed == 0) begin
        $display("Test passed");
      end else begin
        $display("Test failed");
      end
      $finish;
    end
  end

endmodule

/* dv/parking_lot_ctrl_chk.sv */
`timescale 1ns/1ps

module parking_lot_ctrl_chk import parking_pkg::*; (
  input logic               clk,
  input logic               rst,
  input logic               entered,
  input logic               exited,
  input logic               fault,
  input logic [COUNT_W-1:0] count,
  input logic               full,
  input logic               count_error,
  input passage_state_t     state
);

  // at most one passage event per cycle
  a_one_event: assert property (@(posedge clk) disable iff (rst)
    $onehot0({entered, exited, fault}))
    else $error("entered, exited and fault overlap");

  a_entered_width: assert property (@(posedge clk) disable iff (rst)
    entered |=> !entered)
    else $error("entered held longer than one cycle");

  a_exited_width: assert property (@(posedge clk) disable iff (rst)
    exited |=> !exited)
    else $error("exited held longer than one cycle");

  a_fault_width: assert property (@(posedge clk) disable iff (rst)
    fault |=> !fault)
    else $error("fault held longer than one cycle");

  a_count_limit: assert property (@(posedge clk) disable iff (rst)
    count <= COUNT_W'(CAPACITY))
    else $error("count above capacity");

  // full is registered from the next count, so it matches count directly
  a_full_level: assert property (@(posedge clk) disable iff (rst)
    full == (count == COUNT_W'(CAPACITY)))
    else $error("full does not match count");

  a_invalid_exit: assert property (@(posedge clk) disable iff (rst)
    state == ST_INVALID |=> state == ST_IDLE)
    else $error("fsm stayed out of idle after invalid");

  a_reset_values: assert property (@(posedge clk)
    rst |=> (!entered && !exited && !fault && count == '0 && !full && !count_error))
    else $error("outputs not cleared after reset");

endmodule

bind parking_lot_ctrl parking_lot_ctrl_chk u_chk (
  .clk         (clk),
  .rst         (rst),
  .entered     (entered),
  .exited      (exited),
  .fault       (fault),
  .count       (count),
  .full        (full),
  .count_error (count_error),
  .state       (u_passage_fsm.state)
);

/* dv/tb_clkgen.sv */
`timescale 1ns/1ps

module tb_clkgen (
  output logic clk,
  output logic rst
);

  // 10 ns period
  initial begin
    clk = 1'b0;
    forever begin
      #5 clk = ~clk;
    end
  end

  // reset held for 8 cycles, released on a falling edge
  initial begin
    rst = 1'b1;
    repeat (8) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
  end

endmodule

/* design/parking_lot_ctrl.sv */
`timescale 1ns/1ps

module parking_lot_ctrl import parking_pkg::*; (
  input  logic               clk,
  input  logic               rst,
  input  logic               start,
  input  logic               a_raw,
  input  logic               b_raw,
  output logic               entered,
  output logic               exited,
  output logic               fault,
  output logic [COUNT_W-1:0] count,
  output logic               full,
  output logic               count_error
);

  logic a_flt;
  logic b_flt;

  // stage 1, synchronize and debounce the barriers
  sensor_filter u_sensor_filter (
    .clk   (clk),
    .rst   (rst),
    .a_raw (a_raw),
    .b_raw (b_raw),
    .a_flt (a_flt),
    .b_flt (b_flt)
  );

  // stage 2, passage direction tracking
  passage_fsm u_passage_fsm (
    .clk     (clk),
    .rst     (rst),
    .start   (start),
    .a_flt   (a_flt),
    .b_flt   (b_flt),
    .entered (entered),
    .exited  (exited),
    .fault   (fault)
  );

  // stage 3, occupancy against capacity
  occupancy_counter u_occupancy_counter (
    .clk         (clk),
    .rst         (rst),
    .entered     (entered),
    .exited      (exited),
    .count       (count),
    .full        (full),
    .count_error (count_error)
  );

endmodule

/* design/occupancy_counter.sv */
`timescale 1ns/1ps

module occupancy_counter import parking_pkg::*; (
  input  logic               clk,
  input  logic               rst,
  input  logic               entered,
  input  logic               exited,
  output logic [COUNT_W-1:0] count,
  output logic               full,
  output logic               count_error
);

  logic [COUNT_W-1:0] count_nxt;
  logic               error_nxt;

  always_comb begin
    count_nxt = count;
    error_nxt = 1'b0;
    if (entered) begin
      // no space left, hold and flag
      if (count == COUNT_W'(CAPACITY)) begin
        error_nxt = 1'b1;
      end else begin
        count_nxt = count + COUNT_W'(1);
      end
    end else if (exited) begin
      // exit with an empty park, hold and flag
      if (count == '0) begin
        error_nxt = 1'b1;
      end else begin
        count_nxt = count - COUNT_W'(1);
      end
    end
  end

  // full follows the next count so it tracks count in the same cycle
  always_ff @(posedge clk) begin
    if (rst) begin
      count       <= '0;
      full        <= 1'b0;
      count_error <= 1'b0;
    end else begin
      count       <= count_nxt;
      full        <= (count_nxt == COUNT_W'(CAPACITY));
      count_error <= error_nxt;
    end
  end

endmodule

/* design/passage_fsm.sv */
`timescale 1ns/1ps

module passage_fsm import parking_pkg::*; (
  input  logic clk,
  input  logic rst,
  input  logic start,
  input  logic a_flt,
  input  logic b_flt,
  output logic entered,
  output logic exited,
  output logic fault
);

  passage_state_t state;
  passage_state_t state_nxt;
  logic           entered_nxt;
  logic           exited_nxt;
  logic [1:0]     pat;

  // pattern is {a, b}, 1 means blocked
  assign pat = {a_flt, b_flt};

  always_comb begin
    state_nxt   = state;
    entered_nxt = 1'b0;
    exited_nxt  = 1'b0;

    case (state)
      ST_IDLE: begin
        // new passages only start while enabled
        if (start) begin
          case (pat)
            2'b10:   state_nxt = ST_ENTER_A;
            2'b01:   state_nxt = ST_EXIT_B;
            2'b11:   state_nxt = ST_INVALID;
            default: state_nxt = ST_IDLE;
          endcase
        end
      end

      ST_ENTER_A: begin
        case (pat)
          2'b11:   state_nxt = ST_ENTER_AB;
          2'b10:   state_nxt = ST_ENTER_A;
          // car backed out before reaching b
          2'b00:   state_nxt = ST_IDLE;
          default: state_nxt = ST_INVALID;
        endcase
      end

      ST_ENTER_AB: begin
        case (pat)
          2'b01:   state_nxt = ST_ENTER_B;
          2'b11:   state_nxt = ST_ENTER_AB;
          2'b10:   state_nxt = ST_ENTER_A;
          default: state_nxt = ST_INVALID;
        endcase
      end

      ST_ENTER_B: begin
        case (pat)
          2'b00: begin
            state_nxt   = ST_IDLE;
            entered_nxt = 1'b1;
          end
          2'b01:   state_nxt = ST_ENTER_B;
          2'b11:   state_nxt = ST_ENTER_AB;
          default: state_nxt = ST_INVALID;
        endcase
      end

      ST_EXIT_B: begin
        case (pat)
          2'b11:   state_nxt = ST_EXIT_AB;
          2'b01:   state_nxt = ST_EXIT_B;
          2'b00:   state_nxt = ST_IDLE;
          default: state_nxt = ST_INVALID;
        endcase
      end

      ST_EXIT_AB: begin
        case (pat)
          2'b10:   state_nxt = ST_EXIT_A;
          2'b11:   state_nxt = ST_EXIT_AB;
          2'b01:   state_nxt = ST_EXIT_B;
          default: state_nxt = ST_INVALID;
        endcase
      end

      ST_EXIT_A: begin
        case (pat)
          2'b00: begin
            state_nxt  = ST_IDLE;
            exited_nxt = 1'b1;
          end
          2'b10:   state_nxt = ST_EXIT_A;
          2'b11:   state_nxt = ST_EXIT_AB;
          default: state_nxt = ST_INVALID;
        endcase
      end

      // one cycle in invalid, then back to idle
      default: state_nxt = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state   <= ST_IDLE;
      entered <= 1'b0;
      exited  <= 1'b0;
    end else begin
      state   <= state_nxt;
      entered <= entered_nxt;
      exited  <= exited_nxt;
    end
  end

  assign fault = (state == ST_INVALID);

endmodule

/* design/sensor_filter.sv */
`timescale 1ns/1ps

module sensor_filter import parking_pkg::*; (
  input  logic clk,
  input  logic rst,
  input  logic a_raw,
  input  logic b_raw,
  output logic a_flt,
  output logic b_flt
);

  typedef logic [$clog2(DEBOUNCE_CYCLES)-1:0] db_cnt_t;

  // bit 0 carries a, bit 1 carries b
  logic [1:0] raw;
  logic [1:0] sync1;
  logic [1:0] sync2;
  logic [1:0] flt;
  db_cnt_t    cnt [2];

  assign raw = {b_raw, a_raw};

  // two-flop synchronizers for the asynchronous barrier lines
  always_ff @(posedge clk) begin
    if (rst) begin
      sync1 <= '0;
      sync2 <= '0;
    end else begin
      sync1 <= raw;
      sync2 <= sync1;
    end
  end

  // the filtered level flips once the synchronized level has disagreed
  // for DEBOUNCE_CYCLES samples in a row
  always_ff @(posedge clk) begin
    if (rst) begin
      flt <= '0;
      for (int i = 0; i < 2; i++) begin
        cnt[i] <= '0;
      end
    end else begin
      for (int i = 0; i < 2; i++) begin
        if (sync2[i] == flt[i]) begin
          // any agreement restarts the count
          cnt[i] <= '0;
        end else if (cnt[i] == db_cnt_t'(DEBOUNCE_CYCLES - 1)) begin
          flt[i] <= sync2[i];
          cnt[i] <= '0;
        end else begin
          cnt[i] <= cnt[i] + db_cnt_t'(1);
        end
      end
    end
  end

  assign a_flt = flt[0];
  assign b_flt = flt[1];

endmodule

/* design/parking_pkg.sv */
package parking_pkg;

  // passage tracking states, a is the outer barrier and b the inner one
  typedef enum logic [2:0] {
    ST_IDLE     = 3'd0,
    // entering, blocked in the order 10, 11, 01
    ST_ENTER_A  = 3'd1,
    ST_ENTER_AB = 3'd2,
    ST_ENTER_B  = 3'd3,
    // leaving, blocked in the order 01, 11, 10
    ST_EXIT_B   = 3'd4,
    ST_EXIT_AB  = 3'd5,
    ST_EXIT_A   = 3'd6,
    ST_INVALID  = 3'd7
  } passage_state_t;

  // consecutive synchronized samples needed before a filtered line flips
  localparam int unsigned DEBOUNCE_CYCLES = 4;

  // number of spaces in the car park
  localparam int unsigned CAPACITY = 8;

  // occupancy count width, must hold CAPACITY
  localparam int unsigned COUNT_W = 4;

endpackage
